//--- sim.f
rtl/iqPkg.sv
rtl/iqEntryBusIf.sv
rtl/iqReleaseIf.sv
rtl/iqAllocator.sv
rtl/iqEntry.sv
rtl/iqIssueReader.sv
rtl/iqFlushReturn.sv
rtl/issueQueue.sv
tb/issueQueue_props.sv
tb/issueQueueTb.sv

//--- Bender.yml
package:
  name: issue_queue

sources:
  - files:
      - rtl/iqPkg.sv
      - rtl/iqEntryBusIf.sv
      - rtl/iqReleaseIf.sv
      - rtl/iqAllocator.sv
      - rtl/iqEntry.sv
      - rtl/iqIssueReader.sv
      - rtl/iqFlushReturn.sv
      - rtl/issueQueue.sv
  - target: test
    files:
      - tb/issueQueue_props.sv
      - tb/issueQueueTb.sv

//--- tb/issueQueueTb.sv
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for the issue queue entry management.
// Random dispatch, issue and recovery traffic from a fixed seed is
// checked cycle by cycle against a free-list and entry model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module issueQueueTb;
    import iqPkg::*;

    localparam int ENTRY_NUM = 16;
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);
    localparam int COUNT_WIDTH = $clog2(ENTRY_NUM + 1);
    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_CYCLES = 600;
    // Reset, random phase and drain, with ample margin
    localparam int MAX_CYCLES = 2000;

    logic clk = 1'b0;
    logic rstN;
    logic dispatchValid;
    IqPayload dispatchPayload;
    ActiveListPtr dispatchAlPtr;
    logic allocatable;
    logic [INDEX_WIDTH-1:0] dispatchPtr;
    logic [COUNT_WIDTH-1:0] freeCount;
    logic issueValid;
    logic [INDEX_WIDTH-1:0] issuePtr;
    IqPayload issuedPayload;
    ActiveListPtr issuedAlPtr;
    logic recoveryStart;
    ActiveListPtr flushHeadPtr;
    ActiveListPtr flushTailPtr;
    logic [ENTRY_NUM-1:0] flushVec;
    logic returning;

    // Reference model state
    int freeFifo[$];
    bit modelValid[ENTRY_NUM];
    IqPayload modelPayload[ENTRY_NUM];
    ActiveListPtr modelAlPtr[ENTRY_NUM];
    logic [ENTRY_NUM-1:0] modelCaptured;
    bit modelScanning;
    int modelScanIdx;

    int checkCount = 0;
    int errorCount = 0;
    int cycleCount = 0;
    int ignoredDispatches = 0;
    int recoveryCount = 0;
    int assertFails;

    issueQueue #(.ENTRY_NUM(ENTRY_NUM)) issueQueue_i (
        .clk(clk),
        .rstN(rstN),
        .dispatchValid(dispatchValid),
        .dispatchPayload(dispatchPayload),
        .dispatchAlPtr(dispatchAlPtr),
        .allocatable(allocatable),
        .dispatchPtr(dispatchPtr),
        .freeCount(freeCount),
        .issueValid(issueValid),
        .issuePtr(issuePtr),
        .issuedPayload(issuedPayload),
        .issuedAlPtr(issuedAlPtr),
        .recoveryStart(recoveryStart),
        .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr),
        .flushVec(flushVec),
        .returning(returning)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic checkPayload(input string name, input IqPayload got, input IqPayload exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkAlPtr(input string name, input ActiveListPtr got,
                              input ActiveListPtr exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkIndex(input string name, input logic [ENTRY_NUM-1:0] got,
                              input logic [ENTRY_NUM-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // Circular range test, offsets taken modulo 64
    function automatic bit inFlushRange(input int ptr, input int head, input int tail);
        return ((ptr - head + 64) % 64) < ((tail - head + 64) % 64);
    endfunction

    function automatic logic [ENTRY_NUM-1:0] expectedFlushVec();
        logic [ENTRY_NUM-1:0] vec;
        bit written;
        int ptr;
        vec = '0;
        if (recoveryStart) begin
            for (int i = 0; i < ENTRY_NUM; i++) begin
                written = dispatchValid && (freeFifo.size() > 0) && (freeFifo[0] == i);
                ptr = written ? int'(dispatchAlPtr) : int'(modelAlPtr[i]);
                if ((modelValid[i] || written) && !(issueValid && int'(issuePtr) == i)
                        && inFlushRange(ptr, int'(flushHeadPtr), int'(flushTailPtr))) begin
                    vec[i] = 1'b1;
                end
            end
        end
        return vec;
    endfunction

    // Traffic mix changes every 100 cycles: balanced, dispatch heavy, issue heavy
    task automatic driveInputs(input int cycle, input bit drain);
        int validIdx[$];
        int dispatchPct;
        int issuePct;
        dispatchPct = 60;
        issuePct = 50;
        if ((cycle / 100) % 3 == 1) begin
            dispatchPct = 90;
            issuePct = 15;
        end else if ((cycle / 100) % 3 == 2) begin
            dispatchPct = 35;
            issuePct = 75;
        end
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (modelValid[i]) begin
                validIdx.push_back(i);
            end
        end
        dispatchValid = !drain && (cycle < 3 || ($urandom % 100) < dispatchPct);
        dispatchPayload = $urandom;
        dispatchAlPtr = ActiveListPtr'($urandom);
        issuePtr = INDEX_WIDTH'($urandom);
        issueValid = 1'b0;
        if (validIdx.size() > 0 && cycle >= 3) begin
            issuePtr = INDEX_WIDTH'(validIdx[$urandom % validIdx.size()]);
            issueValid = drain || (($urandom % 100) < issuePct);
        end
        flushHeadPtr = ActiveListPtr'($urandom);
        flushTailPtr = ActiveListPtr'($urandom);
        recoveryStart = !drain && !modelScanning && cycle >= 3 && (($urandom % 100) < 5);
    endtask

    task automatic checkOutputs();
        checkFlag("allocatable", allocatable, freeFifo.size() > 0);
        checkIndex("freeCount", freeCount, freeFifo.size());
        if (freeFifo.size() > 0) begin
            checkIndex("dispatchPtr", dispatchPtr, freeFifo[0]);
        end
        if (issueValid) begin
            checkPayload("issuedPayload", issuedPayload, modelPayload[issuePtr]);
            checkAlPtr("issuedAlPtr", issuedAlPtr, modelAlPtr[issuePtr]);
        end
        if (recoveryStart) begin
            checkIndex("flushVec", flushVec, expectedFlushVec());
        end
        checkFlag("returning", returning, modelScanning);
    endtask

    // Applies one rising edge to the model
    task automatic advanceModel();
        logic [ENTRY_NUM-1:0] fv;
        int popIdx;
        fv = expectedFlushVec();
        popIdx = -1;
        if (dispatchValid && freeFifo.size() == 0) begin
            ignoredDispatches++;
        end
        if (dispatchValid && freeFifo.size() > 0) begin
            popIdx = freeFifo.pop_front();
        end
        // Issue release goes in ahead of the flush return
        if (issueValid) begin
            freeFifo.push_back(int'(issuePtr));
        end
        if (modelScanning && modelCaptured[modelScanIdx]) begin
            freeFifo.push_back(modelScanIdx);
        end
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (fv[i] || (issueValid && int'(issuePtr) == i)) begin
                modelValid[i] = 1'b0;
            end else if (i == popIdx) begin
                modelValid[i] = 1'b1;
                modelPayload[i] = dispatchPayload;
                modelAlPtr[i] = dispatchAlPtr;
            end
        end
        if (recoveryStart) begin
            recoveryCount++;
            modelScanning = 1'b1;
            modelScanIdx = 0;
            modelCaptured = fv;
        end else if (modelScanning) begin
            if (modelScanIdx == ENTRY_NUM - 1) begin
                modelScanning = 1'b0;
                modelScanIdx = 0;
            end else begin
                modelScanIdx++;
            end
        end
    endtask

    task automatic runCycle(input int cycle, input bit drain);
        driveInputs(cycle, drain);
        #(CLK_PERIOD / 4);
        checkOutputs();
        @(posedge clk);
        advanceModel();
        @(negedge clk);
    endtask

    function automatic bit anyValid();
        for (int i = 0; i < ENTRY_NUM; i++) begin
            if (modelValid[i]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    initial begin
        void'($urandom(78));
        rstN = 1'b0;
        dispatchValid = 1'b0;
        dispatchPayload = '0;
        dispatchAlPtr = '0;
        issueValid = 1'b0;
        issuePtr = '0;
        recoveryStart = 1'b0;
        flushHeadPtr = '0;
        flushTailPtr = '0;
        for (int i = 0; i < ENTRY_NUM; i++) begin
            freeFifo.push_back(i);
            modelValid[i] = 1'b0;
        end
        modelScanning = 1'b0;
        modelScanIdx = 0;
        modelCaptured = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            runCycle(c, 1'b0);
        end
        // Drain: issue what is left and let any scan finish
        for (int n = 0; n < 4 * ENTRY_NUM && (anyValid() || modelScanning); n++) begin
            runCycle(RANDOM_CYCLES + n, 1'b1);
        end
        issueValid = 1'b0;
        #(CLK_PERIOD / 4);
        checkIndex("freeCount", freeCount, ENTRY_NUM);

        if (ignoredDispatches == 0) begin
            errorCount++;
            $display("The free list never ran empty under dispatch traffic");
        end
        if (recoveryCount == 0) begin
            errorCount++;
            $display("No recovery was started during the run");
        end

        assertFails = issueQueue_i.props_i.failCount;
        $display("Checks %0d, errors %0d, assertion failures %0d, recoveries %0d",
                 checkCount, errorCount, assertFails, recoveryCount);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : issueQueueTb

`default_nettype wire

//--- tb/issueQueue_props.sv
////////////////////////////////////////////////////////////////////////////
// Concurrent properties on the free-list count and the index returns.
// Bound into the queue top level, reads the sequencer state inside it
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module issueQueue_props #(
    parameter int ENTRY_NUM = 16,
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM),
    localparam int COUNT_WIDTH = $clog2(ENTRY_NUM + 1)
) (
    input logic clk,
    input logic rstN,
    input logic [COUNT_WIDTH-1:0] freeCount,
    input iqPkg::FlushReturnState state,
    input logic returning,
    input logic [ENTRY_NUM-1:0] slotValid,
    input logic releaseValid,
    input logic [INDEX_WIDTH-1:0] releasePtr,
    input logic returnValid,
    input logic [INDEX_WIDTH-1:0] returnPtr
);
    import iqPkg::*;

    int failCount = 0;

    freeCountBound: assert property (@(posedge clk) disable iff (!rstN)
        freeCount <= COUNT_WIDTH'(ENTRY_NUM))
    else begin
        failCount++;
        $error("Free count 0x%h above the queue size", freeCount);
    end

    // A returned slot was flushed and stays empty until its index is back
    returnOnlyInScan: assert property (@(posedge clk) disable iff (!rstN)
        returnValid |-> state == returnScan && !slotValid[returnPtr])
    else begin
        failCount++;
        $error("Index 0x%h returned outside the scan or from a valid slot", returnPtr);
    end

    // A slot cannot be both issued and flushed
    distinctPushes: assert property (@(posedge clk) disable iff (!rstN)
        (releaseValid && returnValid) |-> releasePtr != returnPtr)
    else begin
        failCount++;
        $error("Same index 0x%h released and returned together", releasePtr);
    end

    scanLength: assert property (@(posedge clk) disable iff (!rstN)
        $rose(returning) |-> returning [*ENTRY_NUM] ##1 !returning)
    else begin
        failCount++;
        $error("Return scan length differs from the queue size");
    end

endmodule : issueQueue_props

bind issueQueue issueQueue_props #(.ENTRY_NUM(ENTRY_NUM)) props_i (
    .clk(clk),
    .rstN(rstN),
    .freeCount(freeCount),
    .state(flushReturn_i.state),
    .returning(returning),
    .slotValid(entryBus.valid),
    .releaseValid(releaseBus.releaseValid),
    .releasePtr(releaseBus.releasePtr),
    .returnValid(releaseBus.returnValid),
    .returnPtr(releaseBus.returnPtr)
);

`default_nettype wire

//--- rtl/issueQueue.sv
////////////////////////////////////////////////////////////////////////////
// Issue queue entry management top level. One allocator feeds the
// slots, the issue reader and the flush-return sequencer drain them
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module issueQueue #(
    parameter int ENTRY_NUM = 16,
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM),
    localparam int COUNT_WIDTH = $clog2(ENTRY_NUM + 1)
) (
    input  logic clk,
    input  logic rstN,
    // Dispatch
    input  logic dispatchValid,
    input  iqPkg::IqPayload dispatchPayload,
    input  iqPkg::ActiveListPtr dispatchAlPtr,
    output logic allocatable,
    output logic [INDEX_WIDTH-1:0] dispatchPtr,
    output logic [COUNT_WIDTH-1:0] freeCount,
    // Issue
    input  logic issueValid,
    input  logic [INDEX_WIDTH-1:0] issuePtr,
    output iqPkg::IqPayload issuedPayload,
    output iqPkg::ActiveListPtr issuedAlPtr,
    // Recovery
    input  logic recoveryStart,
    input  iqPkg::ActiveListPtr flushHeadPtr,
    input  iqPkg::ActiveListPtr flushTailPtr,
    output logic [ENTRY_NUM-1:0] flushVec,
    output logic returning
);

    iqEntryBusIf #(.ENTRY_NUM(ENTRY_NUM)) entryBus ();
    iqReleaseIf #(.ENTRY_NUM(ENTRY_NUM)) releaseBus ();

    iqAllocator #(.ENTRY_NUM(ENTRY_NUM)) allocator_i (
        .clk(clk),
        .rstN(rstN),
        .dispatchValid(dispatchValid),
        .dispatchPayload(dispatchPayload),
        .dispatchAlPtr(dispatchAlPtr),
        .allocatable(allocatable),
        .dispatchPtr(dispatchPtr),
        .freeCount(freeCount),
        .bus(entryBus.allocator),
        .relBus(releaseBus.freeList)
    );

    for (genvar i = 0; i < ENTRY_NUM; i++) begin : gEntry
        iqEntry #(
            .ENTRY_NUM(ENTRY_NUM),
            .ENTRY_INDEX(i)
        ) entry_i (
            .clk(clk),
            .rstN(rstN),
            .bus(entryBus.entry)
        );
    end

    iqIssueReader #(.ENTRY_NUM(ENTRY_NUM)) issueReader_i (
        .issueValid(issueValid),
        .issuePtr(issuePtr),
        .issuedPayload(issuedPayload),
        .issuedAlPtr(issuedAlPtr),
        .bus(entryBus.reader),
        .relBus(releaseBus.reader)
    );

    iqFlushReturn #(.ENTRY_NUM(ENTRY_NUM)) flushReturn_i (
        .clk(clk),
        .rstN(rstN),
        .recoveryStart(recoveryStart),
        .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr),
        .flushVec(flushVec),
        .returning(returning),
        .bus(entryBus.flushReturn),
        .relBus(releaseBus.returner)
    );

endmodule : issueQueue

`default_nettype wire

//--- rtl/iqFlushReturn.sv
////////////////////////////////////////////////////////////////////////////
// Recovery front end and flush-return sequencer. Captures the flush
// vector and walks every index once, returning the flushed ones
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module iqFlushReturn #(
    parameter int ENTRY_NUM = 16,
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM)
) (
    input  logic clk,
    input  logic rstN,
    input  logic recoveryStart,
    input  iqPkg::ActiveListPtr flushHeadPtr,
    input  iqPkg::ActiveListPtr flushTailPtr,
    output logic [ENTRY_NUM-1:0] flushVec,
    output logic returning,
    iqEntryBusIf.flushReturn bus,
    iqReleaseIf.returner relBus
);
    import iqPkg::*;

    FlushReturnState state;
    logic [ENTRY_NUM-1:0] capturedVec;
    logic [ENTRY_NUM-1:0] pendingVec;
    logic [INDEX_WIDTH-1:0] scanIdx;

    assign bus.flushStart = recoveryStart;
    assign bus.flushHeadPtr = flushHeadPtr;
    assign bus.flushTailPtr = flushTailPtr;
    assign flushVec = bus.flush;

    assign returning = (state == returnScan);
    assign relBus.returnValid = returning && capturedVec[scanIdx];
    assign relBus.returnPtr = scanIdx;

    // Bits the running scan has not reached yet, kept across a restart
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            pendingVec[i] = returning && capturedVec[i] && (INDEX_WIDTH'(i) > scanIdx);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= returnIdle;
            scanIdx <= '0;
        end else if (recoveryStart) begin
            state <= returnScan;
            scanIdx <= '0;
        end else begin
            case (state)
                returnIdle: begin
                    scanIdx <= '0;
                end
                returnScan: begin
                    if (scanIdx == INDEX_WIDTH'(ENTRY_NUM - 1)) begin
                        state <= returnIdle;
                        scanIdx <= '0;
                    end else begin
                        scanIdx <= scanIdx + 1'b1;
                    end
                end
                default: state <= returnIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (recoveryStart) begin
            capturedVec <= bus.flush | pendingVec;
        end
    end

endmodule : iqFlushReturn

`default_nettype wire

//--- rtl/iqIssueReader.sv
////////////////////////////////////////////////////////////////////////////
// Reads the payload of the issued slot and hands its index back
// to the free list in the same cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module iqIssueReader #(
    parameter int ENTRY_NUM = 16,
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM)
) (
    input  logic issueValid,
    input  logic [INDEX_WIDTH-1:0] issuePtr,
    output iqPkg::IqPayload issuedPayload,
    output iqPkg::ActiveListPtr issuedAlPtr,
    iqEntryBusIf.reader bus,
    iqReleaseIf.reader relBus
);

    assign issuedPayload = bus.payload[issuePtr];
    assign issuedAlPtr = bus.alPtr[issuePtr];

    // Clear strobe for the issued slot
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            bus.issueEn[i] = issueValid && (issuePtr == INDEX_WIDTH'(i));
        end
    end

    // Only a live entry gives its index back
    assign relBus.releaseValid = issueValid && bus.valid[issuePtr];
    assign relBus.releasePtr = issuePtr;

endmodule : iqIssueReader

`default_nettype wire

//--- rtl/iqEntry.sv
////////////////////////////////////////////////////////////////////////////
// One issue queue slot with valid bit, payload and active-list pointer.
// Decides its own selective flush during a recovery cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module iqEntry #(
    parameter int ENTRY_NUM = 16,
    parameter int ENTRY_INDEX = 0
) (
    input logic clk,
    input logic rstN,
    iqEntryBusIf.entry bus
);
    import iqPkg::*;

    logic validReg;
    IqPayload payloadReg;
    ActiveListPtr alPtrReg;
    ActiveListPtr checkPtr;
    ActiveListPtr ptrOffset;
    ActiveListPtr tailOffset;
    logic writeHit;
    logic flushHit;

    if (ENTRY_INDEX >= ENTRY_NUM) begin : gIndexCheck
        $error("Slot index %0d outside the queue of %0d", ENTRY_INDEX, ENTRY_NUM);
    end

    assign writeHit = bus.writeEn[ENTRY_INDEX];

    // A dispatch in the recovery cycle is judged by its incoming pointer
    always_comb begin
        checkPtr = writeHit ? bus.writeAlPtr : alPtrReg;
        ptrOffset = checkPtr - bus.flushHeadPtr;
        tailOffset = bus.flushTailPtr - bus.flushHeadPtr;
        // An entry leaving by issue this cycle is already released
        flushHit = bus.flushStart && (validReg || writeHit) && !bus.issueEn[ENTRY_INDEX]
            && (ptrOffset < tailOffset);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validReg <= 1'b0;
        end else if (flushHit || bus.issueEn[ENTRY_INDEX]) begin
            validReg <= 1'b0;
        end else if (writeHit) begin
            validReg <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (writeHit) begin
            payloadReg <= bus.writeData;
            alPtrReg <= bus.writeAlPtr;
        end
    end

    assign bus.valid[ENTRY_INDEX] = validReg;
    assign bus.payload[ENTRY_INDEX] = payloadReg;
    assign bus.alPtr[ENTRY_INDEX] = alPtrReg;
    assign bus.flush[ENTRY_INDEX] = flushHit;

endmodule : iqEntry

`default_nettype wire

//--- rtl/iqAllocator.sv
////////////////////////////////////////////////////////////////////////////
// Free list of entry indices, kept as a circular FIFO. Pops one index
// per accepted dispatch and takes up to two pushes per cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module iqAllocator #(
    parameter int ENTRY_NUM = 16,
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM),
    localparam int COUNT_WIDTH = $clog2(ENTRY_NUM + 1)
) (
    input  logic clk,
    input  logic rstN,
    input  logic dispatchValid,
    input  iqPkg::IqPayload dispatchPayload,
    input  iqPkg::ActiveListPtr dispatchAlPtr,
    output logic allocatable,
    output logic [INDEX_WIDTH-1:0] dispatchPtr,
    output logic [COUNT_WIDTH-1:0] freeCount,
    iqEntryBusIf.allocator bus,
    iqReleaseIf.freeList relBus
);

    logic [INDEX_WIDTH-1:0] fifoMem [ENTRY_NUM];
    logic [INDEX_WIDTH-1:0] headPtr;
    logic [INDEX_WIDTH-1:0] tailPtr;
    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] pushNum;
    logic pop;

    // Circular pointer advance for sizes that are not a power of two
    function automatic logic [INDEX_WIDTH-1:0] wrapAdd(
        input logic [INDEX_WIDTH-1:0] ptr,
        input int step
    );
        int sum;
        sum = int'(ptr) + step;
        if (sum >= ENTRY_NUM) begin
            sum = sum - ENTRY_NUM;
        end
        return INDEX_WIDTH'(sum);
    endfunction

    assign allocatable = (count != '0);
    assign pop = dispatchValid && allocatable;
    assign dispatchPtr = fifoMem[headPtr];
    assign freeCount = count;
    assign pushNum = COUNT_WIDTH'(relBus.releaseValid) + COUNT_WIDTH'(relBus.returnValid);

    // Write decode of the popped index
    always_comb begin
        for (int i = 0; i < ENTRY_NUM; i++) begin
            bus.writeEn[i] = pop && (dispatchPtr == INDEX_WIDTH'(i));
        end
    end

    assign bus.writeData = dispatchPayload;
    assign bus.writeAlPtr = dispatchAlPtr;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            // Free list starts full, indices in ascending order
            for (int i = 0; i < ENTRY_NUM; i++) begin
                fifoMem[i] <= INDEX_WIDTH'(i);
            end
            headPtr <= '0;
            tailPtr <= '0;
            count <= COUNT_WIDTH'(ENTRY_NUM);
        end else begin
            if (pop) begin
                headPtr <= wrapAdd(headPtr, 1);
            end
            // Released index goes first, returned index behind it
            if (relBus.releaseValid) begin
                fifoMem[tailPtr] <= relBus.releasePtr;
            end
            if (relBus.returnValid) begin
                fifoMem[relBus.releaseValid ? wrapAdd(tailPtr, 1) : tailPtr] <= relBus.returnPtr;
            end
            tailPtr <= wrapAdd(tailPtr, int'(pushNum));
            count <= count + pushNum - COUNT_WIDTH'(pop);
        end
    end

endmodule : iqAllocator

`default_nettype wire

//--- rtl/iqReleaseIf.sv
////////////////////////////////////////////////////////////////////////////
// Index return path into the free list. The issue reader releases
// issued indices and the sequencer returns flushed ones
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface iqReleaseIf #(
    parameter int ENTRY_NUM = 16
) ();
    localparam int INDEX_WIDTH = $clog2(ENTRY_NUM);

    logic releaseValid;
    logic [INDEX_WIDTH-1:0] releasePtr;
    logic returnValid;
    logic [INDEX_WIDTH-1:0] returnPtr;

    modport reader (output releaseValid, releasePtr);
    modport returner (output returnValid, returnPtr);
    modport freeList (input releaseValid, releasePtr, returnValid, returnPtr);

endinterface : iqReleaseIf

`default_nettype wire

//--- rtl/iqEntryBusIf.sv
////////////////////////////////////////////////////////////////////////////
// Bus between the allocator, the entry slots, the issue reader and
// the flush-return sequencer. Per-entry vectors are indexed by slot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

interface iqEntryBusIf #(
    parameter int ENTRY_NUM = 16
) ();
    import iqPkg::*;

    // Dispatch write, from the allocator
    logic [ENTRY_NUM-1:0] writeEn;
    IqPayload writeData;
    ActiveListPtr writeAlPtr;

    // Recovery range, from the sequencer
    logic flushStart;
    ActiveListPtr flushHeadPtr;
    ActiveListPtr flushTailPtr;

    // Issue strobe per slot, from the reader
    logic [ENTRY_NUM-1:0] issueEn;

    // Slot state, each slot drives its own element
    logic [ENTRY_NUM-1:0] valid;
    IqPayload payload [ENTRY_NUM];
    ActiveListPtr alPtr [ENTRY_NUM];
    logic [ENTRY_NUM-1:0] flush;

    modport allocator (output writeEn, writeData, writeAlPtr);

    modport entry (
        input writeEn, writeData, writeAlPtr,
        input flushStart, flushHeadPtr, flushTailPtr, issueEn,
        output valid, payload, alPtr, flush
    );

    modport reader (output issueEn, input valid, payload, alPtr);

    modport flushReturn (output flushStart, flushHeadPtr, flushTailPtr, input flush);

endinterface : iqEntryBusIf

`default_nettype wire

//--- rtl/iqPkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types of the issue queue entry management
// Imported by the queue modules, the entry interface and the testbench
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package iqPkg;

    // Active-list position, wraps modulo 64
    localparam int ACTIVE_LIST_PTR_WIDTH = 6;
    typedef logic [ACTIVE_LIST_PTR_WIDTH-1:0] ActiveListPtr;

    // One operation's payload word
    localparam int PAYLOAD_WIDTH = 32;
    typedef logic [PAYLOAD_WIDTH-1:0] IqPayload;

    // Flush-return sequencer
    typedef enum logic {
        returnIdle,
        returnScan
    } FlushReturnState;

endpackage : iqPkg

`default_nettype wire
